// File: rtl/shape_pkg.sv
package shape_pkg;

    // ==================================================
    // Canvas geometry
    // ==================================================
    localparam int canvas_width  = 320;
    localparam int canvas_height = 240;
    localparam int canvas_pixels = canvas_width * canvas_height;

    // Coordinate, address and feature widths
    typedef logic [8:0]  x_t;
    typedef logic [7:0]  y_t;
    typedef logic [16:0] addr_t;
    typedef logic [16:0] count_t;
    typedef logic [9:0]  dim_t;

    // ==================================================
    // Shape codes
    // ==================================================
    typedef enum logic [2:0] {
        shape_none      = 3'd0,
        shape_rectangle = 3'd1,
        shape_square    = 3'd2,
        shape_triangle  = 3'd3,
        shape_circle    = 3'd4
    } shape_e;

    // ==================================================
    // Classification thresholds
    // ==================================================
    // Fill ratio is count * 256 / box area
    localparam int fill_scale_shift = 8;

    localparam int high_fill_min   = 192;
    localparam int circle_fill_min = 170;
    // Exclusive upper bound
    localparam int circle_fill_max = 220;

    // Square aspect when |w - h| < min(w, h) >> 3
    localparam int aspect_tol_shift = 3;

endpackage

// File: rtl/canvas_ram.sv
`timescale 1ns/1ps

module canvas_ram (
    input  logic                clk,
    input  logic                reset_n,
    input  shape_pkg::addr_t    addr,
    input  logic                wr_en,
    input  logic                wr_data,
    output logic                rd_data
);

    // One bit per pixel, row-major
    logic mem [shape_pkg::canvas_pixels];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rd_data <= 1'b0;
        end else begin
            rd_data <= mem[addr];
        end
    end

endmodule

// File: rtl/recognizer_control.sv
`timescale 1ns/1ps

module recognizer_control (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                clear_canvas,
    input  logic                start_recognition,
    input  logic                recognition_done,
    output logic                clear_active,
    output shape_pkg::addr_t    clear_addr,
    output logic                draw_allowed,
    output logic                scan_start,
    output logic                busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_analyze,
        st_done
    } state_e;

    state_e state;

    // ==================================================
    // Main FSM and clear sweep
    // ==================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state        <= st_idle;
            clear_active <= 1'b0;
            clear_addr   <= '0;
            scan_start   <= 1'b0;
        end else begin
            scan_start <= 1'b0;

            case (state)
                st_idle: begin
                    // Clear wins over a start in the same cycle
                    if (clear_canvas && !clear_active) begin
                        clear_active <= 1'b1;
                        clear_addr   <= '0;
                    end else if (start_recognition && !clear_active) begin
                        state      <= st_analyze;
                        scan_start <= 1'b1;
                    end
                end
                st_analyze: begin
                    if (recognition_done) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    // Hold until the request is released
                    if (!start_recognition) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase

            if (clear_active) begin
                if (clear_addr == shape_pkg::addr_t'(shape_pkg::canvas_pixels - 1)) begin
                    clear_active <= 1'b0;
                    clear_addr   <= '0;
                end else begin
                    clear_addr <= clear_addr + 1'b1;
                end
            end
        end
    end

    assign draw_allowed = (state == st_idle) && !clear_active;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy <= 1'b0;
        end else begin
            busy <= clear_active || (state != st_idle);
        end
    end

endmodule

// File: rtl/canvas_port_arbiter.sv
`timescale 1ns/1ps

module canvas_port_arbiter (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                clear_active,
    input  shape_pkg::addr_t    clear_addr,
    input  logic                draw_allowed,
    input  logic                draw_en,
    input  shape_pkg::x_t       draw_x,
    input  shape_pkg::y_t       draw_y,
    input  logic                draw_pixel_on,
    input  logic                scan_read,
    input  shape_pkg::addr_t    scan_addr,
    output shape_pkg::addr_t    ram_addr,
    output logic                ram_wr_en,
    output logic                ram_wr_data
);

    shape_pkg::addr_t draw_addr;
    logic             draw_go;

    // Row-major: y * width + x
    assign draw_addr = shape_pkg::addr_t'(draw_y) * shape_pkg::addr_t'(shape_pkg::canvas_width)
                     + shape_pkg::addr_t'(draw_x);

    assign draw_go = draw_en && draw_allowed;

    // ==================================================
    // Port control, priority clear > draw > scan
    // ==================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ram_wr_en <= 1'b0;
        end else begin
            ram_wr_en <= clear_active || draw_go;
        end
    end

    // Address and write data
    always_ff @(posedge clk) begin
        if (clear_active) begin
            ram_addr    <= clear_addr;
            ram_wr_data <= 1'b0;
        end else if (draw_go) begin
            ram_addr    <= draw_addr;
            ram_wr_data <= draw_pixel_on;
        end else if (scan_read) begin
            ram_addr <= scan_addr;
        end
        // Idle cycles keep the last address on the port
    end

endmodule

// File: rtl/feature_scanner.sv
`timescale 1ns/1ps

module feature_scanner (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                scan_start,
    input  logic                rd_data,
    output logic                scan_read,
    output shape_pkg::addr_t    scan_addr,
    output shape_pkg::count_t   pixel_count,
    output shape_pkg::dim_t     bbox_width,
    output shape_pkg::dim_t     bbox_height,
    output logic                features_valid
);

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_wait,
        st_proc,
        st_box
    } state_e;

    localparam shape_pkg::x_t last_x = shape_pkg::x_t'(shape_pkg::canvas_width - 1);
    localparam shape_pkg::y_t last_y = shape_pkg::y_t'(shape_pkg::canvas_height - 1);

    state_e        state;
    shape_pkg::x_t scan_x;
    shape_pkg::y_t scan_y;
    shape_pkg::x_t min_x;
    shape_pkg::x_t max_x;
    shape_pkg::y_t min_y;
    shape_pkg::y_t max_y;

    // Current pixel address, raster order
    assign scan_addr = shape_pkg::addr_t'(scan_y) * shape_pkg::addr_t'(shape_pkg::canvas_width)
                     + shape_pkg::addr_t'(scan_x);

    // One read request per pixel
    assign scan_read = (state == st_addr);

    // ==================================================
    // Scan FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state          <= st_idle;
            features_valid <= 1'b0;
        end else begin
            features_valid <= 1'b0;

            case (state)
                st_idle: begin
                    if (scan_start) begin
                        state <= st_addr;
                    end
                end
                // Arbiter registers the address
                st_addr: state <= st_wait;
                // RAM registers the data
                st_wait: state <= st_proc;
                st_proc: begin
                    if (scan_x == last_x && scan_y == last_y) begin
                        state <= st_box;
                    end else begin
                        state <= st_addr;
                    end
                end
                st_box: begin
                    features_valid <= 1'b1;
                    state          <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Counters, box extents and results
    always_ff @(posedge clk) begin
        if (state == st_idle && scan_start) begin
            scan_x      <= '0;
            scan_y      <= '0;
            pixel_count <= '0;
            min_x       <= last_x;
            max_x       <= '0;
            min_y       <= last_y;
            max_y       <= '0;
        end else if (state == st_proc) begin
            if (rd_data) begin
                pixel_count <= pixel_count + 1'b1;
                if (scan_x < min_x) min_x <= scan_x;
                if (scan_x > max_x) max_x <= scan_x;
                if (scan_y < min_y) min_y <= scan_y;
                if (scan_y > max_y) max_y <= scan_y;
            end

            // Step to the next pixel
            if (scan_x == last_x) begin
                scan_x <= '0;
                scan_y <= scan_y + 1'b1;
            end else begin
                scan_x <= scan_x + 1'b1;
            end
        end else if (state == st_box) begin
            if (pixel_count != '0) begin
                bbox_width  <= shape_pkg::dim_t'(max_x) - shape_pkg::dim_t'(min_x) + 1'b1;
                bbox_height <= shape_pkg::dim_t'(max_y) - shape_pkg::dim_t'(min_y) + 1'b1;
            end else begin
                bbox_width  <= '0;
                bbox_height <= '0;
            end
        end
    end

endmodule

// File: rtl/shape_classifier.sv
`timescale 1ns/1ps

module shape_classifier (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                features_valid,
    input  shape_pkg::count_t   pixel_count,
    input  shape_pkg::dim_t     bbox_width,
    input  shape_pkg::dim_t     bbox_height,
    output logic                recognition_done,
    output shape_pkg::shape_e   detected_shape
);

    typedef enum logic [1:0] {
        st_idle,
        st_area,
        st_ratios,
        st_classify
    } state_e;

    state_e            state;

    // Latched features
    shape_pkg::count_t count_q;
    shape_pkg::dim_t   width_q;
    shape_pkg::dim_t   height_q;

    // Box area, up to 1023 * 1023
    logic [19:0]       area_q;

    // Ratio stage, combinational
    logic [24:0]       fill_num;
    logic [24:0]       fill_ratio;
    shape_pkg::dim_t   aspect_diff;
    shape_pkg::dim_t   min_dim;

    // Flags registered for the decision stage
    logic              high_fill;
    logic              circle_fill;
    logic              square_aspect;

    // ==================================================
    // Fill ratio and aspect
    // ==================================================
    assign fill_num = {count_q, 8'd0} >> (8 - shape_pkg::fill_scale_shift);

    always_comb begin
        if (area_q == '0) begin
            fill_ratio = '0;
        end else begin
            fill_ratio = fill_num / 25'(area_q);
        end

        if (width_q > height_q) begin
            aspect_diff = width_q - height_q;
            min_dim     = height_q;
        end else begin
            aspect_diff = height_q - width_q;
            min_dim     = width_q;
        end
    end

    // ==================================================
    // Pipeline sequencing
    // ==================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state            <= st_idle;
            recognition_done <= 1'b0;
            detected_shape   <= shape_pkg::shape_none;
        end else begin
            recognition_done <= 1'b0;

            case (state)
                st_idle: begin
                    if (features_valid) begin
                        state <= st_area;
                    end
                end
                st_area: begin
                    // Empty canvas, nothing to measure
                    if (count_q == '0) begin
                        detected_shape   <= shape_pkg::shape_none;
                        recognition_done <= 1'b1;
                        state            <= st_idle;
                    end else begin
                        state <= st_ratios;
                    end
                end
                st_ratios: state <= st_classify;
                st_classify: begin
                    if (high_fill && square_aspect) begin
                        detected_shape <= shape_pkg::shape_square;
                    end else if (high_fill) begin
                        detected_shape <= shape_pkg::shape_rectangle;
                    end else if (square_aspect && circle_fill) begin
                        detected_shape <= shape_pkg::shape_circle;
                    end else begin
                        detected_shape <= shape_pkg::shape_triangle;
                    end
                    recognition_done <= 1'b1;
                    state            <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Datapath registers, one stage each
    always_ff @(posedge clk) begin
        if (state == st_idle && features_valid) begin
            count_q  <= pixel_count;
            width_q  <= bbox_width;
            height_q <= bbox_height;
        end
        if (state == st_area) begin
            area_q <= width_q * height_q;
        end
        if (state == st_ratios) begin
            high_fill     <= fill_ratio >= 25'(shape_pkg::high_fill_min);
            circle_fill   <= (fill_ratio >= 25'(shape_pkg::circle_fill_min))
                          && (fill_ratio < 25'(shape_pkg::circle_fill_max));
            square_aspect <= aspect_diff < (min_dim >> shape_pkg::aspect_tol_shift);
        end
    end

endmodule

// File: rtl/shape_recognizer.sv
`timescale 1ns/1ps

module shape_recognizer (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                draw_en,
    input  shape_pkg::x_t       draw_x,
    input  shape_pkg::y_t       draw_y,
    input  logic                draw_pixel_on,
    input  logic                clear_canvas,
    input  logic                start_recognition,
    output logic                busy,
    output logic                recognition_done,
    output shape_pkg::shape_e   detected_shape
);

    // Control
    logic              clear_active;
    shape_pkg::addr_t  clear_addr;
    logic              draw_allowed;
    logic              scan_start;

    // RAM port
    shape_pkg::addr_t  ram_addr;
    logic              ram_wr_en;
    logic              ram_wr_data;
    logic              rd_data;

    // Scanner
    logic              scan_read;
    shape_pkg::addr_t  scan_addr;
    shape_pkg::count_t pixel_count;
    shape_pkg::dim_t   bbox_width;
    shape_pkg::dim_t   bbox_height;
    logic              features_valid;

    recognizer_control u_control (
        .clk               (clk),
        .reset_n           (reset_n),
        .clear_canvas      (clear_canvas),
        .start_recognition (start_recognition),
        .recognition_done  (recognition_done),
        .clear_active      (clear_active),
        .clear_addr        (clear_addr),
        .draw_allowed      (draw_allowed),
        .scan_start        (scan_start),
        .busy              (busy)
    );

    canvas_port_arbiter u_arbiter (
        .clk           (clk),
        .reset_n       (reset_n),
        .clear_active  (clear_active),
        .clear_addr    (clear_addr),
        .draw_allowed  (draw_allowed),
        .draw_en       (draw_en),
        .draw_x        (draw_x),
        .draw_y        (draw_y),
        .draw_pixel_on (draw_pixel_on),
        .scan_read     (scan_read),
        .scan_addr     (scan_addr),
        .ram_addr      (ram_addr),
        .ram_wr_en     (ram_wr_en),
        .ram_wr_data   (ram_wr_data)
    );

    canvas_ram u_ram (
        .clk     (clk),
        .reset_n (reset_n),
        .addr    (ram_addr),
        .wr_en   (ram_wr_en),
        .wr_data (ram_wr_data),
        .rd_data (rd_data)
    );

    feature_scanner u_scanner (
        .clk            (clk),
        .reset_n        (reset_n),
        .scan_start     (scan_start),
        .rd_data        (rd_data),
        .scan_read      (scan_read),
        .scan_addr      (scan_addr),
        .pixel_count    (pixel_count),
        .bbox_width     (bbox_width),
        .bbox_height    (bbox_height),
        .features_valid (features_valid)
    );

    shape_classifier u_classifier (
        .clk              (clk),
        .reset_n          (reset_n),
        .features_valid   (features_valid),
        .pixel_count      (pixel_count),
        .bbox_width       (bbox_width),
        .bbox_height      (bbox_height),
        .recognition_done (recognition_done),
        .detected_shape   (detected_shape)
    );

endmodule

// File: tests/shape_recognizer_tb.sv
`timescale 1ns/1ps

module shape_recognizer_tb;

    localparam real clk_period = 20.0;

    // Seven clears and six three-cycle scans plus half again as margin
    localparam real run_cycles = 7.0 * shape_pkg::canvas_pixels
                               + 6.0 * 3.0 * shape_pkg::canvas_pixels;
    localparam real watchdog_ns = run_cycles * clk_period * 1.5;

    logic              clk;
    logic              reset_n;
    logic              draw_en;
    shape_pkg::x_t     draw_x;
    shape_pkg::y_t     draw_y;
    logic              draw_pixel_on;
    logic              clear_canvas;
    logic              start_recognition;
    logic              busy;
    logic              recognition_done;
    shape_pkg::shape_e detected_shape;

    // Software copy of the canvas
    bit     shadow [shape_pkg::canvas_height][shape_pkg::canvas_width];
    int     px_q[$];
    int     py_q[$];
    integer seed;
    int     error_count;
    int     tests_run;
    int     x0;
    int     y0;

    shape_recognizer DUT (
        .clk               (clk),
        .reset_n           (reset_n),
        .draw_en           (draw_en),
        .draw_x            (draw_x),
        .draw_y            (draw_y),
        .draw_pixel_on     (draw_pixel_on),
        .clear_canvas      (clear_canvas),
        .start_recognition (start_recognition),
        .busy              (busy),
        .recognition_done  (recognition_done),
        .detected_shape    (detected_shape)
    );

    always #(clk_period / 2.0) clk = ~clk;

    // ==================================================
    // Reference model
    // ==================================================
    function automatic shape_pkg::shape_e expected_shape();
        int count;
        int min_x;
        int max_x;
        int min_y;
        int max_y;
        int w;
        int h;
        int fill;
        int diff;
        int min_side;
        bit high;
        bit square;
        count = 0;
        min_x = shape_pkg::canvas_width;
        max_x = -1;
        min_y = shape_pkg::canvas_height;
        max_y = -1;
        for (int r = 0; r < shape_pkg::canvas_height; r++) begin
            for (int c = 0; c < shape_pkg::canvas_width; c++) begin
                if (shadow[r][c]) begin
                    count++;
                    min_x = (c < min_x) ? c : min_x;
                    max_x = (c > max_x) ? c : max_x;
                    min_y = (r < min_y) ? r : min_y;
                    max_y = (r > max_y) ? r : max_y;
                end
            end
        end
        if (count == 0) begin
            return shape_pkg::shape_none;
        end
        w = max_x - min_x + 1;
        h = max_y - min_y + 1;
        fill = (count << shape_pkg::fill_scale_shift) / (w * h);
        diff = (w > h) ? w - h : h - w;
        min_side = (w < h) ? w : h;
        high = fill >= shape_pkg::high_fill_min;
        square = diff < (min_side >> shape_pkg::aspect_tol_shift);
        if (high && square) return shape_pkg::shape_square;
        if (high) return shape_pkg::shape_rectangle;
        if (square && fill >= shape_pkg::circle_fill_min && fill < shape_pkg::circle_fill_max)
            return shape_pkg::shape_circle;
        return shape_pkg::shape_triangle;
    endfunction

    // ==================================================
    // Pixel list builders
    // ==================================================
    task automatic queue_block(input int bx, input int by, input int w, input int h);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                px_q.push_back(bx + c);
                py_q.push_back(by + r);
            end
        end
    endtask

    // Right angle at the bottom left with a staircase hypotenuse
    task automatic queue_triangle(input int bx, input int by, input int legs);
        for (int r = 0; r < legs; r++) begin
            for (int c = 0; c <= r; c++) begin
                px_q.push_back(bx + c);
                py_q.push_back(by + r);
            end
        end
    endtask

    // Square with a staircase cut off each corner
    task automatic queue_rounded(input int bx, input int by, input int size, input int cut);
        int dr;
        int dc;
        for (int r = 0; r < size; r++) begin
            for (int c = 0; c < size; c++) begin
                dr = (r < size - 1 - r) ? r : size - 1 - r;
                dc = (c < size - 1 - c) ? c : size - 1 - c;
                if (dr + dc >= cut) begin
                    px_q.push_back(bx + c);
                    py_q.push_back(by + r);
                end
            end
        end
    endtask

    task automatic pick_offset();
        x0 = 8 + ($unsigned($random(seed)) % 200);
        y0 = 8 + ($unsigned($random(seed)) % 120);
    endtask

    // ==================================================
    // Bus-level tasks
    // ==================================================
    task automatic draw_queued(input bit record);
        for (int i = 0; i < px_q.size(); i++) begin
            @(negedge clk);
            draw_en       = 1'b1;
            draw_x        = shape_pkg::x_t'(px_q[i]);
            draw_y        = shape_pkg::y_t'(py_q[i]);
            draw_pixel_on = 1'b1;
            if (record) begin
                shadow[py_q[i]][px_q[i]] = 1'b1;
            end
        end
        @(negedge clk);
        draw_en = 1'b0;
        px_q.delete();
        py_q.delete();
    endtask

    task automatic start_erase();
        @(negedge clk);
        clear_canvas = 1'b1;
        @(negedge clk);
        clear_canvas = 1'b0;
        while (!busy) @(negedge clk);
        for (int r = 0; r < shape_pkg::canvas_height; r++) begin
            for (int c = 0; c < shape_pkg::canvas_width; c++) begin
                shadow[r][c] = 1'b0;
            end
        end
    endtask

    task automatic wait_until_idle();
        while (busy) @(negedge clk);
    endtask

    task automatic erase_canvas();
        start_erase();
        wait_until_idle();
    endtask

    task automatic recognize_and_check(input int test_no, input string name,
                                       input shape_pkg::shape_e intended);
        shape_pkg::shape_e expected;
        int errors_before;
        bit busy_gap;
        expected = expected_shape();
        errors_before = error_count;
        busy_gap = 1'b0;
        assert (expected == intended) else begin
            $display("Stimulus for %s does not form the intended shape in the model", name);
            error_count++;
        end
        @(negedge clk);
        start_recognition = 1'b1;
        @(negedge clk);
        start_recognition = 1'b0;
        // busy is registered, so it shows one cycle after the start is taken
        @(negedge clk);
        while (!recognition_done) begin
            if (!busy) busy_gap = 1'b1;
            @(negedge clk);
        end
        assert (!busy_gap) else begin
            $display("** Error at %0t: %s busy low before recognition_done", $time, name);
            error_count++;
        end
        assert (detected_shape == expected) else begin
            $display("** Error at %0t: %s expected shape %0d, observed %0d",
                     $time, name, expected, detected_shape);
            error_count++;
        end
        @(negedge clk);
        assert (!recognition_done) else begin
            $display("** Error at %0t: %s recognition_done longer than one cycle", $time, name);
            error_count++;
        end
        wait_until_idle();
        tests_run++;
        $display("Test %0d %s: %s", test_no, name,
                 (error_count == errors_before) ? "pass" : "fail");
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        clk               = 1'b0;
        reset_n           = 1'b0;
        draw_en           = 1'b0;
        draw_x            = '0;
        draw_y            = '0;
        draw_pixel_on     = 1'b0;
        clear_canvas      = 1'b0;
        start_recognition = 1'b0;
        seed              = 32'h2a87;
        error_count       = 0;
        tests_run         = 0;
        repeat (8) @(negedge clk);
        reset_n = 1'b1;

        erase_canvas();
        recognize_and_check(1, "empty canvas", shape_pkg::shape_none);

        erase_canvas();
        pick_offset();
        queue_block(x0, y0, 40, 40);
        draw_queued(1'b1);
        recognize_and_check(2, "40x40 block", shape_pkg::shape_square);

        erase_canvas();
        pick_offset();
        queue_block(x0, y0, 80, 30);
        draw_queued(1'b1);
        recognize_and_check(3, "80x30 block", shape_pkg::shape_rectangle);

        erase_canvas();
        pick_offset();
        queue_triangle(x0, y0, 60);
        draw_queued(1'b1);
        recognize_and_check(4, "right triangle", shape_pkg::shape_triangle);

        erase_canvas();
        pick_offset();
        queue_rounded(x0, y0, 40, 14);
        draw_queued(1'b1);
        recognize_and_check(5, "rounded block", shape_pkg::shape_circle);

        // Draws during a clear must not reach the canvas
        erase_canvas();
        pick_offset();
        queue_block(x0, y0, 30, 30);
        draw_queued(1'b1);
        start_erase();
        // Hold the draws until the sweep has passed the block
        repeat (shape_pkg::canvas_pixels - 2 * 30 * 30) @(negedge clk);
        queue_block(x0, y0, 30, 30);
        draw_queued(1'b0);
        wait_until_idle();
        recognize_and_check(6, "draws while busy", shape_pkg::shape_none);

        $display("Tests run: %0d, errors: %0d", tests_run, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired at %0t, the DUT stopped responding", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: compile.f
rtl/shape_pkg.sv
rtl/canvas_ram.sv
rtl/recognizer_control.sv
rtl/canvas_port_arbiter.sv
rtl/feature_scanner.sv
rtl/shape_classifier.sv
rtl/shape_recognizer.sv
tests/shape_recognizer_tb.sv
